//--- files.f
+incdir+tests
hw/cpu_pkg.sv
hw/pipe_if.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/cpu_top.sv
tests/cpu_tb.sv

//--- hw/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int       NUM_REGS         = 32;
    localparam reg_idx_t REG_ZERO         = 5'd0;
    localparam u32_t     RESET_PC_DEFAULT = 32'h1c00_0000;

    // Major opcode in inst[31:26]. Codes outside this list decode to OP_NOP.
    typedef enum logic [5:0] {
        OP_NOP     = 6'h00,
        OP_ADD_W   = 6'h01,
        OP_SUB_W   = 6'h02,
        OP_AND     = 6'h03,
        OP_OR      = 6'h04,
        OP_XOR     = 6'h05,
        OP_SLT     = 6'h06,
        OP_ADDI_W  = 6'h07,
        OP_LU12I_W = 6'h08,
        OP_BEQ     = 6'h09,
        OP_BNE     = 6'h0a
    } op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        u32_t pc;
        u32_t inst;
    } fd_pass_t;

    typedef struct packed {
        u32_t     pc;
        u32_t     inst;
        op_e      op;
        reg_idx_t rd;
        u32_t     src_a;   // Operands after forwarding.
        u32_t     src_b;
        u32_t     imm;
        logic     wen;     // Never set for rd r0.
    } de_pass_t;

    typedef struct packed {
        u32_t     pc;
        u32_t     inst;
        reg_idx_t rd;
        logic     wen;
        u32_t     result;
    } ew_pass_t;

    typedef struct packed {
        logic valid;
        u32_t target;
    } redirect_t;

endpackage

//--- hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter u32_t RESET_PC = RESET_PC_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_i,

    output logic        icache_req_o,
    output u32_t        icache_pa_o,
    input  logic        icache_ready_i,
    input  u32_t        icache_data_i,
    input  logic        icache_data_valid_i,
    output logic        icache_data_ready_o,

    output logic        debug_wb_valid_o,
    output u32_t        debug_wb_pc_o,
    output u32_t        debug_wb_inst_o,
    output logic [3:0]  debug_wb_rf_wen_o,
    output reg_idx_t    debug_wb_rf_wnum_o,
    output u32_t        debug_wb_rf_wdata_o
);

    fd_if fd_bus ();
    de_if de_bus ();
    ew_if ew_bus ();

    redirect_t redirect;
    reg_idx_t  rj;
    reg_idx_t  rk;
    u32_t      rj_data;
    u32_t      rk_data;
    logic      rf_we;
    reg_idx_t  rf_idx;
    u32_t      rf_data;

    assign fd_bus.flush = redirect.valid;  // Taken branch kills the fetch output.

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk, .rst_i,
        .redirect_i (redirect),
        .icache_req_o, .icache_pa_o, .icache_ready_i,
        .icache_data_i, .icache_data_valid_i, .icache_data_ready_o,
        .fd         (fd_bus)
    );

    reg_file u_reg_file (
        .clk, .rst_i,
        .rj_i      (rj),
        .rk_i      (rk),
        .rj_data_o (rj_data),
        .rk_data_o (rk_data),
        .we_i      (rf_we),
        .wd_idx_i  (rf_idx),
        .wd_data_i (rf_data)
    );

    decode_stage u_decode (
        .clk, .rst_i,
        .redirect_i (redirect),
        .fd         (fd_bus),
        .ew_fwd     (ew_bus),
        .rj_o       (rj),
        .rk_o       (rk),
        .rj_data_i  (rj_data),
        .rk_data_i  (rk_data),
        .de         (de_bus)
    );

    execute_stage u_execute (
        .clk, .rst_i,
        .de         (de_bus),
        .redirect_o (redirect),
        .ew         (ew_bus)
    );

    writeback_stage u_writeback (
        .clk, .rst_i,
        .ew        (ew_bus),
        .rf_we_o   (rf_we),
        .rf_idx_o  (rf_idx),
        .rf_data_o (rf_data),
        .debug_wb_valid_o, .debug_wb_pc_o, .debug_wb_inst_o,
        .debug_wb_rf_wen_o, .debug_wb_rf_wnum_o, .debug_wb_rf_wdata_o
    );

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  redirect_t redirect_i,
    fd_if.consumer    fd,
    ew_if.consumer    ew_fwd,
    output reg_idx_t  rj_o,
    output reg_idx_t  rk_o,
    input  u32_t      rj_data_i,
    input  u32_t      rk_data_i,
    de_if.producer    de
);

    u32_t     inst;
    op_e      op;
    reg_idx_t rd;
    logic     is_branch;
    logic     writes;
    u32_t     imm;
    u32_t     src_a;
    u32_t     src_b;
    logic     de_valid_q;
    de_pass_t de_q;

    assign inst = fd.payload.inst;
    assign rd   = inst[4:0];

    always_comb begin
        case (inst[31:26])
            OP_ADD_W, OP_SUB_W, OP_AND, OP_OR, OP_XOR, OP_SLT,
            OP_ADDI_W, OP_LU12I_W, OP_BEQ, OP_BNE: op = op_e'(inst[31:26]);
            default:                               op = OP_NOP;
        endcase
    end

    assign is_branch = (op == OP_BEQ) || (op == OP_BNE);
    assign writes    = !is_branch && (op != OP_NOP);

    // Branches compare rj with the register named in the rd field.
    assign rj_o = inst[9:5];
    assign rk_o = is_branch ? rd : inst[14:10];

    always_comb begin
        case (op)
            OP_ADDI_W:      imm = {{20{inst[21]}}, inst[21:10]};
            OP_LU12I_W:     imm = {inst[24:5], 12'h000};
            OP_BEQ, OP_BNE: imm = {{16{inst[25]}}, inst[25:10]};
            default:        imm = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding from execute. Writeback is covered by the register file bypass.
    ////////////////////////////////////////////////////////////////////////////

    assign src_a = (ew_fwd.fwd_valid && ew_fwd.fwd_rd == rj_o) ? ew_fwd.fwd_data : rj_data_i;
    assign src_b = (ew_fwd.fwd_valid && ew_fwd.fwd_rd == rk_o) ? ew_fwd.fwd_data : rk_data_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            de_valid_q <= 1'b0;
        end else begin
            de_valid_q <= fd.valid & ~redirect_i.valid;  // Younger than a taken branch.
        end
    end

    always_ff @(posedge clk) begin
        de_q.pc    <= fd.payload.pc;
        de_q.inst  <= inst;
        de_q.op    <= op;
        de_q.rd    <= rd;
        de_q.src_a <= src_a;
        de_q.src_b <= src_b;
        de_q.imm   <= imm;
        de_q.wen   <= writes && (rd != REG_ZERO);
    end

    assign de.valid   = de_valid_q;
    assign de.payload = de_q;

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    de_if.consumer    de,
    output redirect_t redirect_o,
    ew_if.producer    ew
);

    de_pass_t in;
    u32_t     result;
    logic     less;
    logic     taken;
    logic     ew_valid_q;
    ew_pass_t ew_q;

    assign in   = de.payload;
    assign less = $signed(in.src_a) < $signed(in.src_b);

    always_comb begin
        case (in.op)
            OP_ADD_W:   result = in.src_a + in.src_b;
            OP_SUB_W:   result = in.src_a - in.src_b;
            OP_AND:     result = in.src_a & in.src_b;
            OP_OR:      result = in.src_a | in.src_b;
            OP_XOR:     result = in.src_a ^ in.src_b;
            OP_SLT:     result = {31'b0, less};
            OP_ADDI_W:  result = in.src_a + in.imm;
            OP_LU12I_W: result = in.imm;  // Upper 20 bits were placed by decode.
            default:    result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch resolution. Fetch always predicts fall-through.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (in.op)
            OP_BEQ:  taken = (in.src_a == in.src_b);
            OP_BNE:  taken = (in.src_a != in.src_b);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o.valid  = de.valid & taken;
    assign redirect_o.target = in.pc + {in.imm[29:0], 2'b00};

    // The result of the instruction now in execute, seen by decode this cycle.
    assign ew.fwd_valid = de.valid & in.wen;
    assign ew.fwd_rd    = in.rd;
    assign ew.fwd_data  = result;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ew_valid_q <= 1'b0;
        end else begin
            ew_valid_q <= de.valid;
        end
    end

    always_ff @(posedge clk) begin
        ew_q.pc     <= in.pc;
        ew_q.inst   <= in.inst;
        ew_q.rd     <= in.rd;
        ew_q.wen    <= in.wen;
        ew_q.result <= result;
    end

    assign ew.valid   = ew_valid_q;
    assign ew.payload = ew_q;

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
    parameter u32_t RESET_PC = RESET_PC_DEFAULT
) (
    input  logic      clk,
    input  logic      rst_i,
    input  redirect_t redirect_i,

    output logic      icache_req_o,
    output u32_t      icache_pa_o,
    input  logic      icache_ready_i,
    input  u32_t      icache_data_i,
    input  logic      icache_data_valid_i,
    output logic      icache_data_ready_o,

    fd_if.producer    fd
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT_DATA
    } state_e;

    state_e state_q;
    u32_t   pa_q;      // Address of the request in flight.
    u32_t   tgt_q;     // Redirect target held until the stale return is gone.
    logic   stale_q;
    logic   accept;
    logic   ret;

    assign icache_req_o        = (state_q == S_REQ);
    assign icache_pa_o         = pa_q;
    assign icache_data_ready_o = (state_q == S_WAIT_DATA);

    assign accept = icache_req_o & icache_ready_i;
    assign ret    = icache_data_ready_o & icache_data_valid_i;

    // A return younger than a taken branch never reaches decode.
    assign fd.valid   = ret & ~stale_q & ~fd.flush;
    assign fd.payload = '{pc: pa_q, inst: icache_data_i};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            pa_q    <= RESET_PC;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE:      state_q <= S_REQ;
                S_REQ:       if (accept) state_q <= S_WAIT_DATA;
                S_WAIT_DATA: if (ret) state_q <= S_REQ;
                default:     state_q <= S_IDLE;
            endcase

            if (ret) begin
                stale_q <= 1'b0;
                if (redirect_i.valid) begin
                    pa_q <= redirect_i.target;
                end else if (stale_q) begin
                    pa_q <= tgt_q;
                end else begin
                    pa_q <= pa_q + 32'd4;
                end
            end else if (redirect_i.valid) begin
                // The address must hold while a request waits, so the target is parked.
                if (state_q == S_IDLE) begin
                    pa_q <= redirect_i.target;
                end else begin
                    stale_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_i.valid) begin
            tgt_q <= redirect_i.target;
        end
    end

endmodule

//--- hw/pipe_if.sv
`timescale 1ns/1ps

// Fetch to decode. The flush input kills the word on the bus in the same cycle.
interface fd_if import cpu_pkg::*; ();
    logic     valid;
    fd_pass_t payload;
    logic     flush;

    modport producer (output valid, output payload, input flush);
    modport consumer (input valid, input payload, input flush);
endinterface

interface de_if import cpu_pkg::*; ();
    logic     valid;
    de_pass_t payload;

    modport producer (output valid, output payload);
    modport consumer (input valid, input payload);
endinterface

// Execute to writeback, plus the forwarding view of the instruction now in execute.
interface ew_if import cpu_pkg::*; ();
    logic     valid;
    ew_pass_t payload;
    logic     fwd_valid;
    reg_idx_t fwd_rd;
    u32_t     fwd_data;

    modport producer (
        output valid,
        output payload,
        output fwd_valid,
        output fwd_rd,
        output fwd_data
    );
    modport consumer (
        input valid,
        input payload,
        input fwd_valid,
        input fwd_rd,
        input fwd_data
    );
endinterface

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  reg_idx_t rj_i,
    input  reg_idx_t rk_i,
    output u32_t     rj_data_o,
    output u32_t     rk_data_o,
    input  logic     we_i,
    input  reg_idx_t wd_idx_i,
    input  u32_t     wd_data_i
);

    u32_t regs_q [NUM_REGS];

    // Write-first. A read of the register being written sees the new value.
    function automatic u32_t read_port(input reg_idx_t idx);
        if (idx == REG_ZERO) begin
            return '0;
        end else if (we_i && wd_idx_i == idx) begin
            return wd_data_i;
        end
        return regs_q[idx];
    endfunction

    assign rj_data_o = read_port(rj_i);
    assign rk_data_o = read_port(rk_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && wd_idx_i != REG_ZERO) begin
            regs_q[wd_idx_i] <= wd_data_i;
        end
    end

endmodule

//--- hw/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    ew_if.consumer      ew,

    output logic        rf_we_o,
    output reg_idx_t    rf_idx_o,
    output u32_t        rf_data_o,

    output logic        debug_wb_valid_o,
    output u32_t        debug_wb_pc_o,
    output u32_t        debug_wb_inst_o,
    output logic [3:0]  debug_wb_rf_wen_o,
    output reg_idx_t    debug_wb_rf_wnum_o,
    output u32_t        debug_wb_rf_wdata_o
);

    logic do_write;

    assign do_write  = ew.valid & ew.payload.wen;
    assign rf_we_o   = do_write;
    assign rf_idx_o  = ew.payload.rd;
    assign rf_data_o = ew.payload.result;

    // Retirement record, one cycle behind the register file write.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            debug_wb_valid_o  <= 1'b0;
            debug_wb_rf_wen_o <= 4'h0;
        end else begin
            debug_wb_valid_o  <= ew.valid;
            debug_wb_rf_wen_o <= {4{do_write}};
        end
    end

    always_ff @(posedge clk) begin
        debug_wb_pc_o       <= ew.payload.pc;
        debug_wb_inst_o     <= ew.payload.inst;
        debug_wb_rf_wnum_o  <= ew.payload.rd;
        debug_wb_rf_wdata_o <= ew.payload.result;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module cpu_tb -f files.f \
        -Mdir obj_dir -o cpu_tb_sim; then
    echo "Verilator build failed."
    exit 1
fi

if ! ./obj_dir/cpu_tb_sim; then
    echo "Simulation reported a failure."
    exit 1
fi

echo "Simulation finished cleanly."
exit 0

//--- tests/ref_model.svh
// One entry of the expected retirement stream.
typedef struct packed {
    u32_t     pc;
    u32_t     inst;
    logic     wen;
    reg_idx_t wnum;
    u32_t     wdata;
} retire_t;

localparam int IMEM_WORDS = 256;

integer seed;
u32_t   imem [IMEM_WORDS];       // Indexed by pc bits 9:2, so the program wraps.
u32_t   model_regs [NUM_REGS];
u32_t   model_pc;

function automatic reg_idx_t pick_reg();
    return reg_idx_t'($unsigned($random(seed)) % 8);  // r0 to r7 keeps dependencies dense.
endfunction

function automatic u32_t random_inst();
    u32_t inst;
    int   pick;
    inst      = $random(seed);
    pick      = $unsigned($random(seed)) % 12;
    inst[4:0] = pick_reg();
    case (pick)
        0:       inst[31:26] = OP_ADD_W;
        1:       inst[31:26] = OP_SUB_W;
        2:       inst[31:26] = OP_AND;
        3:       inst[31:26] = OP_OR;
        4:       inst[31:26] = OP_XOR;
        5:       inst[31:26] = OP_SLT;
        6:       inst[31:26] = OP_ADDI_W;
        7:       inst[31:26] = OP_LU12I_W;
        8:       inst[31:26] = OP_BEQ;
        9:       inst[31:26] = OP_BNE;
        default: inst[31]    = 1'b1;  // Opcodes 0x20 and up are undefined.
    endcase
    if (pick < 6) begin
        inst[9:5]   = pick_reg();
        inst[14:10] = pick_reg();
    end else if (pick == 6) begin
        inst[9:5] = pick_reg();
    end else if (pick == 8 || pick == 9) begin
        inst[9:5]   = pick_reg();
        inst[25:10] = 16'(1 + $unsigned($random(seed)) % 8);  // Short forward hop.
    end
    return inst;
endfunction

task automatic build_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
        imem[i] = random_inst();
    end
endtask

task automatic reset_model();
    for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    model_pc = RESET_PC_DEFAULT;
endtask

////////////////////////////////////////////////////////////////////////////
// Architectural step of one instruction.
////////////////////////////////////////////////////////////////////////////

function automatic retire_t next_retirement();
    retire_t  r;
    u32_t     inst;
    u32_t     a;
    u32_t     b;
    u32_t     c;
    u32_t     res;
    u32_t     next_pc;
    logic     writes;
    inst    = imem[model_pc[9:2]];
    a       = model_regs[inst[9:5]];
    b       = model_regs[inst[14:10]];
    c       = model_regs[inst[4:0]];   // Second branch source sits in the rd field.
    res     = '0;
    writes  = 1'b1;
    next_pc = model_pc + 32'd4;
    case (inst[31:26])
        OP_ADD_W:   res = a + b;
        OP_SUB_W:   res = a - b;
        OP_AND:     res = a & b;
        OP_OR:      res = a | b;
        OP_XOR:     res = a ^ b;
        OP_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_ADDI_W:  res = a + {{20{inst[21]}}, inst[21:10]};
        OP_LU12I_W: res = {inst[24:5], 12'h000};
        OP_BEQ, OP_BNE: begin
            writes = 1'b0;
            if ((a == c) == (inst[31:26] == OP_BEQ)) begin
                next_pc = model_pc + {{14{inst[25]}}, inst[25:10], 2'b00};
            end
        end
        default:    writes = 1'b0;
    endcase
    r.pc    = model_pc;
    r.inst  = inst;
    r.wen   = writes && (inst[4:0] != REG_ZERO);
    r.wnum  = inst[4:0];
    r.wdata = res;
    if (r.wen) begin
        model_regs[inst[4:0]] = res;
    end
    model_pc = next_pc;
    return r;
endfunction

//--- tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam u32_t BOOT_PC    = RESET_PC_DEFAULT;
    localparam int   NUM_RETIRE = 500;
    localparam int   WAIT_LIMIT = 1000;

    logic       clk = 1'b0;
    logic       rst_i;
    logic       icache_req_o;
    u32_t       icache_pa_o;
    logic       icache_ready_i;
    u32_t       icache_data_i;
    logic       icache_data_valid_i;
    logic       icache_data_ready_o;
    logic       debug_wb_valid_o;
    u32_t       debug_wb_pc_o;
    u32_t       debug_wb_inst_o;
    logic [3:0] debug_wb_rf_wen_o;
    reg_idx_t   debug_wb_rf_wnum_o;
    u32_t       debug_wb_rf_wdata_o;
    int         retired;
    logic       first_accept_seen;
    bit         accepted_pa [u32_t];  // Every address the cache accepted.

    `include "ref_model.svh"

    cpu_top #(.RESET_PC (BOOT_PC)) uut (
        .clk, .rst_i,
        .icache_req_o, .icache_pa_o, .icache_ready_i,
        .icache_data_i, .icache_data_valid_i, .icache_data_ready_o,
        .debug_wb_valid_o, .debug_wb_pc_o, .debug_wb_inst_o,
        .debug_wb_rf_wen_o, .debug_wb_rf_wnum_o, .debug_wb_rf_wdata_o
    );

    always #50 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check_word(input string name, input u32_t exp, input u32_t act);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            fail_now("A checked word did not match.");
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
            fail_now("A checked register index did not match.");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction cache responder, driven on the falling edge.
    ////////////////////////////////////////////////////////////////////////////

    task automatic serve_request();
        u32_t pa;
        int   cycles;
        int   hold;
        cycles = 0;
        while (icache_req_o !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (icache_req_o !== 1'b1) begin
            fail_now("Fetch raised no instruction request within the timeout.");
        end
        pa   = icache_pa_o;
        hold = $unsigned($random(seed)) % 4;
        repeat (hold) begin
            @(negedge clk);
            check_word("icache_req_o", 32'd1, {31'b0, icache_req_o});  // Request must hold.
            check_word("icache_pa_o", pa, icache_pa_o);
        end
        icache_ready_i = 1'b1;
        @(negedge clk);
        icache_ready_i = 1'b0;
        if (!first_accept_seen) begin
            check_word("icache_pa_o", BOOT_PC, pa);
            first_accept_seen = 1'b1;
        end
        accepted_pa[pa] = 1'b1;
        hold = $unsigned($random(seed)) % 4;
        repeat (hold) @(negedge clk);
        check_word("icache_data_ready_o", 32'd1, {31'b0, icache_data_ready_o});
        icache_data_i       = imem[pa[9:2]];
        icache_data_valid_i = 1'b1;
        @(negedge clk);
        icache_data_valid_i = 1'b0;
    endtask

    initial begin : responder
        icache_ready_i      = 1'b0;
        icache_data_i       = '0;
        icache_data_valid_i = 1'b0;
        first_accept_seen   = 1'b0;
        forever serve_request();
    end

    task automatic wait_retirement();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (debug_wb_valid_o !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (debug_wb_valid_o !== 1'b1) begin
            fail_now("No instruction retired within the timeout.");
        end
    endtask

    task automatic compare_retirement(input retire_t exp);
        check_word("debug_wb_pc_o", exp.pc, debug_wb_pc_o);
        check_word("debug_wb_inst_o", exp.inst, debug_wb_inst_o);
        if (!accepted_pa.exists(debug_wb_pc_o)) begin
            fail_now("An instruction retired from an address that was never requested.");
        end
        if (exp.wen) begin
            check_word("debug_wb_rf_wen_o", 32'hf, {28'b0, debug_wb_rf_wen_o});
            check_idx("debug_wb_rf_wnum_o", exp.wnum, debug_wb_rf_wnum_o);
            check_word("debug_wb_rf_wdata_o", exp.wdata, debug_wb_rf_wdata_o);
        end else begin
            check_word("debug_wb_rf_wen_o", 32'h0, {28'b0, debug_wb_rf_wen_o});
        end
    endtask

    initial begin : run
        retire_t exp;
        rst_i   = 1'b1;
        seed    = 32'hcf67;
        retired = 0;
        build_program();
        reset_model();
        repeat (4) @(negedge clk);
        check_word("icache_req_o", 32'd0, {31'b0, icache_req_o});
        check_word("debug_wb_valid_o", 32'd0, {31'b0, debug_wb_valid_o});
        check_word("debug_wb_rf_wen_o", 32'd0, {28'b0, debug_wb_rf_wen_o});
        rst_i = 1'b0;
        while (retired < NUM_RETIRE) begin
            wait_retirement();
            exp = next_retirement();
            compare_retirement(exp);
            retired++;
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
